//--- common/bomber_consts.svh
`ifndef BOMBER_CONSTS_SVH
`define BOMBER_CONSTS_SVH

// ---------------------------------------------------------------------
// map geometry
// ---------------------------------------------------------------------
`define NUM_ROW       11                    // tiles per column
`define NUM_COL       19                    // tiles per row
`define TILE_SHIFT    6                     // 64 pixel tiles
`define MAP_DEPTH     (`NUM_ROW * `NUM_COL) // 209 tiles
`define MAP_AW        8                     // holds any address below MAP_DEPTH

// sprite box in pixels, position is the top left corner
`define SPRITE_W      32
`define SPRITE_H      64

// ---------------------------------------------------------------------
// bomb and blast
// ---------------------------------------------------------------------
`define BOMB_TIME     3                     // seconds until it goes off
`define TICKS_PER_SEC 60                    // tick pulses per second
`define BLAST_RANGE   2                     // tiles per arm at most

`endif

//--- common/bomber_pkg.sv
`default_nettype none

`include "bomber_consts.svh"

package bomber_pkg;

  // ---------------------------------------------------------------------
  // tile codes as stored in the map
  // ---------------------------------------------------------------------
  typedef enum logic [1:0] {
    FLOOR = 2'd0,  // walkable, blast passes
    BRICK = 2'd1,  // breakable
    WALL  = 2'd2,  // solid, stops the blast
    BOMB  = 2'd3   // live bomb
  } tile_t;

  // one request on the shared map write port
  typedef struct packed {
    logic              valid;  // held until granted
    logic [`MAP_AW-1:0] addr;
    tile_t             tile;
  } map_wr_t;

  // ---------------------------------------------------------------------
  // controller states
  // ---------------------------------------------------------------------
  typedef enum logic [1:0] {
    BOMB_IDLE,       // waiting for a press
    BOMB_PLACE,      // writing the bomb tile
    BOMB_COUNTDOWN,  // fuse running
    BOMB_EXPLODE     // one cycle, hands off to the blast
  } bomb_state_t;

  typedef enum logic [2:0] {
    BLAST_IDLE,
    BLAST_CENTER,    // clear the bomb tile
    BLAST_STEP,      // move one tile along the arm
    BLAST_READ,      // look at the scanned tile
    BLAST_DONE       // one cycle done pulse
  } blast_state_t;

  // arm order follows the encoding
  typedef enum logic [1:0] {
    UP    = 2'd0,
    DOWN  = 2'd1,
    LEFT  = 2'd2,
    RIGHT = 2'd3
  } dir_t;

endpackage

`default_nettype wire

//--- bomb/bomb_logic.sv
`default_nettype none

`include "bomber_consts.svh"

module bomb_logic
  import bomber_pkg::*;
(
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               tick,         // one pulse per frame
  input  wire logic [10:0]        player_x,     // sprite top left, pixels
  input  wire logic [9:0]         player_y,
  input  wire logic               place_bomb,   // raw button
  output map_wr_t                 wr_req,
  input  wire logic               wr_grant,
  output logic                    explosion,    // one cycle pulse
  output logic [`MAP_AW-1:0]      bomb_addr,    // tile of the live bomb
  output logic                    bomb_active,
  output logic [1:0]              countdown     // seconds left
);

  localparam int TICK_W = $clog2(`TICKS_PER_SEC);

  bomb_state_t          state;
  logic                 place_q1, place_q2;
  logic                 place_edge;
  logic [TICK_W-1:0]    tick_cnt;               // ticks inside the current second
  logic [10:0]          center_x;
  logic [9:0]           center_y;
  logic [9-`TILE_SHIFT:0]  tile_row;
  logic [10-`TILE_SHIFT:0] tile_col;
  logic [`MAP_AW-1:0]   tile_addr;
  logic [`MAP_AW-1:0]   saved_addr;
  logic                 last_tick;

  // ---------------------------------------------------------------------
  // button sync and rising edge
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      place_q1 <= 1'b0;
      place_q2 <= 1'b0;
    end else begin
      place_q1 <= place_bomb;
      place_q2 <= place_q1;
    end
  end

  assign place_edge = place_q1 & ~place_q2;  // high for one cycle

  // ---------------------------------------------------------------------
  // tile under the sprite centre
  // ---------------------------------------------------------------------
  assign center_x  = player_x + 11'(`SPRITE_W / 2);
  assign center_y  = player_y + 10'(`SPRITE_H / 2);
  assign tile_row  = center_y[9:`TILE_SHIFT];   // divide by tile size
  assign tile_col  = center_x[10:`TILE_SHIFT];
  assign tile_addr = `MAP_AW'(tile_row * `NUM_COL + tile_col);

  // address is frozen at the press so the request stays stable
  always_ff @(posedge clk) begin
    if (state == BOMB_IDLE && place_edge) begin
      saved_addr <= tile_addr;
    end
  end

  // ---------------------------------------------------------------------
  // bomb FSM with fuse counters
  // ---------------------------------------------------------------------
  assign last_tick = tick && (tick_cnt == TICK_W'(`TICKS_PER_SEC - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= BOMB_IDLE;
      countdown <= 2'(`BOMB_TIME);
      tick_cnt  <= '0;
    end else begin
      case (state)
        BOMB_IDLE: begin
          countdown <= 2'(`BOMB_TIME);  // rearm
          tick_cnt  <= '0;
          if (place_edge) state <= BOMB_PLACE;  // presses elsewhere are ignored
        end
        BOMB_PLACE: begin
          if (wr_grant) state <= BOMB_COUNTDOWN;  // bomb tile written at this edge
        end
        BOMB_COUNTDOWN: begin
          if (last_tick) begin
            tick_cnt  <= '0;
            countdown <= countdown - 2'd1;
            if (countdown == 2'd1) state <= BOMB_EXPLODE;
          end else if (tick) begin
            tick_cnt <= tick_cnt + TICK_W'(1);
          end
        end
        BOMB_EXPLODE: begin
          state <= BOMB_IDLE;  // blast block takes over
        end
        default: state <= BOMB_IDLE;
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // outputs
  // ---------------------------------------------------------------------
  assign wr_req.valid = (state == BOMB_PLACE);
  assign wr_req.addr  = saved_addr;
  assign wr_req.tile  = BOMB;
  assign explosion    = (state == BOMB_EXPLODE);
  assign bomb_addr    = saved_addr;
  assign bomb_active  = (state != BOMB_IDLE);

  // request must not move while the arbiter holds it off
  a_req_stable : assert property (@(posedge clk) disable iff (rst)
    (wr_req.valid && !wr_grant) |=> $stable(wr_req));

endmodule

`default_nettype wire

//--- bomb/blast_spread.sv
`default_nettype none

`include "bomber_consts.svh"

module blast_spread
  import bomber_pkg::*;
(
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               explosion,   // start pulse
  input  wire logic [`MAP_AW-1:0] bomb_addr,
  output logic [`MAP_AW-1:0]      scan_addr,   // map read, data one cycle later
  input  tile_t                   scan_tile,
  output map_wr_t                 wr_req,
  input  wire logic               wr_grant,
  output logic                    blast_done
);

  localparam int STEP_W = $clog2(`BLAST_RANGE + 1);

  blast_state_t         state;
  dir_t                 dir;
  logic [STEP_W-1:0]    step_cnt;      // tiles walked on this arm
  logic                 wr_pend;       // brick clear waiting for grant
  logic [`MAP_AW-1:0]   center_addr;
  logic [`MAP_AW-1:0]   cur_addr;
  logic [`MAP_AW-1:0]   next_addr;
  logic                 arm_end;

  // neighbour in the current direction, border walls keep it on the map
  always_comb begin
    case (dir)
      UP:      next_addr = cur_addr - `MAP_AW'(`NUM_COL);
      DOWN:    next_addr = cur_addr + `MAP_AW'(`NUM_COL);
      LEFT:    next_addr = cur_addr - `MAP_AW'(1);
      default: next_addr = cur_addr + `MAP_AW'(1);
    endcase
  end

  // read ahead in STEP, keep reading the current tile in READ
  assign scan_addr = (state == BLAST_STEP) ? next_addr : cur_addr;

  // ---------------------------------------------------------------------
  // arm termination
  // ---------------------------------------------------------------------
  always_comb begin
    arm_end = 1'b0;
    if (state == BLAST_READ) begin
      if (wr_pend) arm_end = wr_grant;                // brick cleared
      else if (scan_tile == WALL) arm_end = 1'b1;     // blocked
      else if (scan_tile != BRICK && step_cnt == STEP_W'(`BLAST_RANGE)) arm_end = 1'b1;
    end
  end

  // ---------------------------------------------------------------------
  // blast FSM
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= BLAST_IDLE;
      dir      <= UP;
      step_cnt <= '0;
      wr_pend  <= 1'b0;
    end else begin
      case (state)
        BLAST_IDLE: begin
          dir      <= UP;
          step_cnt <= '0;
          if (explosion) state <= BLAST_CENTER;
        end
        BLAST_CENTER: begin
          if (wr_grant) state <= BLAST_STEP;  // centre is floor now
        end
        BLAST_STEP: begin
          step_cnt <= step_cnt + STEP_W'(1);
          state    <= BLAST_READ;
        end
        BLAST_READ: begin
          if (wr_pend) begin
            if (wr_grant) wr_pend <= 1'b0;
          end else if (scan_tile == BRICK) begin
            wr_pend <= 1'b1;                 // request from next cycle on
          end else if (!arm_end && scan_tile != WALL) begin
            state <= BLAST_STEP;             // floor, keep walking
          end
          if (arm_end) begin
            step_cnt <= '0;
            if (dir == RIGHT) begin
              state <= BLAST_DONE;
            end else begin
              dir   <= dir_t'(dir + 2'd1);
              state <= BLAST_STEP;
            end
          end
        end
        BLAST_DONE: state <= BLAST_IDLE;
        default:    state <= BLAST_IDLE;
      endcase
    end
  end

  // walk position, each arm restarts at the centre
  always_ff @(posedge clk) begin
    if (state == BLAST_IDLE && explosion) begin
      center_addr <= bomb_addr;
      cur_addr    <= bomb_addr;
    end else if (state == BLAST_STEP) begin
      cur_addr <= next_addr;
    end else if (arm_end) begin
      cur_addr <= center_addr;
    end
  end

  // ---------------------------------------------------------------------
  // outputs
  // ---------------------------------------------------------------------
  assign wr_req.valid = (state == BLAST_CENTER) || wr_pend;
  assign wr_req.addr  = (state == BLAST_CENTER) ? center_addr : cur_addr;
  assign wr_req.tile  = FLOOR;
  assign blast_done   = (state == BLAST_DONE);

  // a pending clear targets the scanned tile, which must never be a wall
  a_no_wall_write : assert property (@(posedge clk) disable iff (rst)
    wr_pend |-> (scan_tile != WALL));

endmodule

`default_nettype wire

//--- verilog/map_write_arbiter.sv
`default_nettype none

`include "bomber_consts.svh"

module map_write_arbiter
  import bomber_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst,
  input  map_wr_t   bomb_req,     // high priority peer
  input  map_wr_t   blast_req,
  output logic      bomb_grant,
  output logic      blast_grant,
  output map_wr_t   map_wr        // to the map write port
);

  logic [4:0] hold_cnt;           // cycles the blast peer has waited

  // ---------------------------------------------------------------------
  // fixed priority select
  // ---------------------------------------------------------------------
  assign bomb_grant  = bomb_req.valid;
  assign blast_grant = blast_req.valid && !bomb_req.valid;

  always_comb begin
    if (bomb_req.valid) map_wr = bomb_req;
    else                map_wr = blast_req;  // valid low when neither asks
  end

  // ---------------------------------------------------------------------
  // starvation watch
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      hold_cnt <= '0;
    end else if (blast_req.valid && !blast_grant) begin
      if (hold_cnt != 5'h1f) hold_cnt <= hold_cnt + 5'd1;  // saturate
    end else begin
      hold_cnt <= '0;
    end
  end

  // bomb writes are single requests, so the blast peer gets through soon
  a_no_starve : assert property (@(posedge clk) disable iff (rst)
    hold_cnt < 5'd16);

endmodule

`default_nettype wire

//--- verilog/tile_map.sv
`default_nettype none

`include "bomber_consts.svh"

module tile_map
  import bomber_pkg::*;
(
  input  wire logic               clk,
  input  wire logic               rst,
  input  map_wr_t                 map_wr,
  input  wire logic [`MAP_AW-1:0] scan_addr,   // blast read port
  output tile_t                   scan_tile,
  input  wire logic [`MAP_AW-1:0] rd_addr,     // display read port
  output tile_t                   rd_tile
);

  tile_t mem [`MAP_DEPTH];                      // row major, row * NUM_COL + col

  // ---------------------------------------------------------------------
  // start layout
  // ---------------------------------------------------------------------
  function automatic tile_t layout_tile(int row, int col);
    if (row == 0 || row == `NUM_ROW - 1 || col == 0 || col == `NUM_COL - 1)
      return WALL;                               // border
    if (row % 2 == 0 && col % 2 == 0)
      return WALL;                               // pillar grid
    if ((row + col) % 3 == 0)
      return BRICK;
    return FLOOR;
  endfunction

  // reset reloads the whole arena at once, otherwise one write per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < `NUM_ROW; r++) begin
        for (int c = 0; c < `NUM_COL; c++) begin
          mem[r * `NUM_COL + c] <= layout_tile(r, c);
        end
      end
    end else if (map_wr.valid) begin
      mem[map_wr.addr] <= map_wr.tile;
    end
  end

  // ---------------------------------------------------------------------
  // registered reads
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    scan_tile <= mem[scan_addr];
    rd_tile   <= mem[rd_addr];
  end

  // peers compute addresses from positions, catch anything off the map
  a_wr_in_map : assert property (@(posedge clk) disable iff (rst)
    map_wr.valid |-> (map_wr.addr < `MAP_AW'(`MAP_DEPTH)));

endmodule

`default_nettype wire

//--- verilog/bomber_arena.sv
`default_nettype none

`include "bomber_consts.svh"

module bomber_arena
  import bomber_pkg::*;
(
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               tick,
  input  wire logic [10:0]        player_x,
  input  wire logic [9:0]         player_y,
  input  wire logic               place_bomb,
  input  wire logic [`MAP_AW-1:0] rd_addr,
  output tile_t                   rd_tile,
  output logic                    bomb_active,
  output logic [1:0]              countdown,
  output logic                    explosion,
  output logic                    blast_done
);

  // ---------------------------------------------------------------------
  // internal nets
  // ---------------------------------------------------------------------
  map_wr_t            bomb_req, blast_req, map_wr;
  logic               bomb_grant, blast_grant;
  logic [`MAP_AW-1:0] bomb_addr;               // handed over on explosion
  logic [`MAP_AW-1:0] scan_addr;
  tile_t              scan_tile;

  bomb_logic i_bomb_logic (
    .clk         (clk),
    .rst         (rst),
    .tick        (tick),
    .player_x    (player_x),
    .player_y    (player_y),
    .place_bomb  (place_bomb),
    .wr_req      (bomb_req),
    .wr_grant    (bomb_grant),
    .explosion   (explosion),
    .bomb_addr   (bomb_addr),
    .bomb_active (bomb_active),
    .countdown   (countdown)
  );

  blast_spread i_blast_spread (
    .clk        (clk),
    .rst        (rst),
    .explosion  (explosion),
    .bomb_addr  (bomb_addr),
    .scan_addr  (scan_addr),
    .scan_tile  (scan_tile),
    .wr_req     (blast_req),
    .wr_grant   (blast_grant),
    .blast_done (blast_done)
  );

  map_write_arbiter i_map_write_arbiter (
    .clk         (clk),
    .rst         (rst),
    .bomb_req    (bomb_req),
    .blast_req   (blast_req),
    .bomb_grant  (bomb_grant),
    .blast_grant (blast_grant),
    .map_wr      (map_wr)
  );

  tile_map i_tile_map (
    .clk       (clk),
    .rst       (rst),
    .map_wr    (map_wr),
    .scan_addr (scan_addr),
    .scan_tile (scan_tile),
    .rd_addr   (rd_addr),
    .rd_tile   (rd_tile)
  );

endmodule

`default_nettype wire

//--- tb/tb_bomber_arena.sv
`default_nettype none

`include "bomber_consts.svh"

module tb_bomber_arena
  import bomber_pkg::*;
();

  localparam int FUSE_TICKS  = `BOMB_TIME * `TICKS_PER_SEC;
  localparam int FUSE_CYCLES = FUSE_TICKS * 4;                 // one tick every 4 cycles
  localparam int NUM_TESTS   = 6;
  localparam int DOG_CYCLES  = NUM_TESTS * (FUSE_CYCLES + 2000);
  localparam int EV_ACTIVE   = 0;
  localparam int EV_BOOM     = 1;
  localparam int EV_DONE     = 2;

  logic               clk, rst, tick, place_bomb;
  logic [10:0]        player_x;
  logic [9:0]         player_y;
  logic [`MAP_AW-1:0] rd_addr;
  tile_t              rd_tile;
  logic               bomb_active, explosion, blast_done;
  logic [1:0]         countdown;

  tile_t model [`MAP_DEPTH];          // expected arena, row major
  int    err_cnt = 0;
  int    fail_cnt = 0;
  int    fuse_ticks, explode_cnt, done_cnt;
  int    tick_phase;
  logic  prev_active;                 // bomb_active one cycle back

  bomber_arena i_bomber_arena (
    .clk (clk), .rst (rst), .tick (tick),
    .player_x (player_x), .player_y (player_y), .place_bomb (place_bomb),
    .rd_addr (rd_addr), .rd_tile (rd_tile),
    .bomb_active (bomb_active), .countdown (countdown),
    .explosion (explosion), .blast_done (blast_done)
  );

  // ---------------------------------------------------------------------
  // clock, tick and watchdog
  // ---------------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    tick = 1'b0;
    tick_phase = 0;
    forever begin
      @(posedge clk);
      #2;
      tick = (tick_phase == 3);          // short seconds keep the run fast
      tick_phase = (tick_phase + 1) % 4;
    end
  end

  initial begin
    repeat (DOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", DOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  // fuse ticks seen by the bomb, PLACE lasts one cycle under priority
  always @(posedge clk) begin
    if (rst) begin
      fuse_ticks  <= 0;
      explode_cnt <= 0;
      done_cnt    <= 0;
      prev_active <= 1'b0;
    end else begin
      prev_active <= bomb_active;
      if (!bomb_active) fuse_ticks <= 0;
      else if (prev_active && !explosion && tick) fuse_ticks <= fuse_ticks + 1;
      if (explosion) explode_cnt <= explode_cnt + 1;
      if (blast_done) done_cnt <= done_cnt + 1;
    end
  end

  // ---------------------------------------------------------------------
  // protocol checks
  // ---------------------------------------------------------------------
  a_fuse_count : assert property (@(posedge clk) disable iff (rst)
    (bomb_active && prev_active)
      |-> (countdown == 2'(`BOMB_TIME - fuse_ticks / `TICKS_PER_SEC)))
    else begin
      err_cnt++;
      $display("ERR countdown exp %0h got %0h",
               2'(`BOMB_TIME - $sampled(fuse_ticks) / `TICKS_PER_SEC), $sampled(countdown));
    end

  a_idle_fuse : assert property (@(posedge clk) disable iff (rst)
    (!bomb_active && !prev_active) |-> (countdown == 2'(`BOMB_TIME)))
    else begin
      err_cnt++;
      $display("ERR countdown exp %0h got %0h", `BOMB_TIME, $sampled(countdown));
    end

  a_boom_time : assert property (@(posedge clk) disable iff (rst)
    explosion |-> (bomb_active && fuse_ticks == FUSE_TICKS))
    else begin
      err_cnt++;
      $display("ERR fuse_ticks exp %0h got %0h", FUSE_TICKS, $sampled(fuse_ticks));
    end

  a_boom_pulse : assert property (@(posedge clk) disable iff (rst) explosion |=> !explosion)
    else begin
      err_cnt++;
      $display("explosion stayed high for more than one cycle");
    end

  a_done_pulse : assert property (@(posedge clk) disable iff (rst) blast_done |=> !blast_done)
    else begin
      err_cnt++;
      $display("blast_done stayed high for more than one cycle");
    end

  // ---------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------
  task automatic step;
    @(posedge clk);
    #2;                                  // inputs move just after the edge
  endtask

  function automatic int spot_addr(int row, int col);
    return row * `NUM_COL + col;
  endfunction

  function automatic tile_t start_tile(int row, int col);
    if (row == 0 || col == 0 || row == `NUM_ROW - 1 || col == `NUM_COL - 1) return WALL;
    if (row % 2 == 0 && col % 2 == 0) return WALL;
    return ((row + col) % 3 == 0) ? BRICK : FLOOR;
  endfunction

  task automatic load_model;
    for (int r = 0; r < `NUM_ROW; r++)
      for (int c = 0; c < `NUM_COL; c++)
        model[spot_addr(r, c)] = start_tile(r, c);
  endtask

  // four arms, first brick goes, walls stop the arm
  task automatic apply_blast(int center);
    int  r, c, a;
    bit  stop;
    model[center] = FLOOR;
    for (int d = 0; d < 4; d++) begin
      r = center / `NUM_COL;
      c = center % `NUM_COL;
      stop = 1'b0;
      for (int k = 1; k <= `BLAST_RANGE && !stop; k++) begin
        case (d)
          0:       r--;
          1:       r++;
          2:       c--;
          default: c++;
        endcase
        a = spot_addr(r, c);
        if (model[a] == WALL) begin
          stop = 1'b1;
        end else if (model[a] == BRICK) begin
          model[a] = FLOOR;
          stop = 1'b1;
        end
      end
    end
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("ERR %s exp %0h got %0h", name, exp, got);
    end
  endtask

  task automatic check_tile(int a);
    rd_addr = `MAP_AW'(a);
    step;                                // one cycle read latency
    check_value($sformatf("rd_tile[%0h]", a), rd_tile, model[a]);
  endtask

  // pipelined sweep, the tile of the previous address arrives each cycle
  task automatic compare_map;
    for (int a = 0; a <= `MAP_DEPTH; a++) begin
      if (a > 0) check_value($sformatf("rd_tile[%0h]", a - 1), rd_tile, model[a - 1]);
      if (a < `MAP_DEPTH) rd_addr = `MAP_AW'(a);
      step;
    end
  endtask

  task automatic pick_spot(output int row, output int col);
    do begin
      row = 1 + int'($urandom % (`NUM_ROW - 2));
      col = 1 + int'($urandom % (`NUM_COL - 2));
    end while (row % 2 == 0 && col % 2 == 0);  // skip pillars
  endtask

  // sprite centre lands anywhere inside the chosen tile
  task automatic move_player(int row, int col);
    player_x = 11'((col << `TILE_SHIFT) + int'($urandom % 64) - `SPRITE_W / 2);
    player_y = 10'((row << `TILE_SHIFT) + int'($urandom % 64) - `SPRITE_H / 2);
  endtask

  task automatic press_button;
    place_bomb = 1'b1;
    repeat (2) step;
    place_bomb = 1'b0;
    repeat (2) step;
  endtask

  function automatic bit reached(int kind, int target);
    case (kind)
      EV_ACTIVE: return bomb_active;
      EV_BOOM:   return explode_cnt >= target;
      default:   return done_cnt >= target;
    endcase
  endfunction

  task automatic wait_for(int kind, int target, int limit, string what);
    int n;
    n = 0;
    while (!reached(kind, target) && n < limit) begin
      step;
      n++;
    end
    assert (reached(kind, target)) else begin
      err_cnt++;
      $display("no %s within %0d cycles", what, limit);
    end
  endtask

  task automatic place_at(int row, int col);
    move_player(row, col);
    press_button;
    wait_for(EV_ACTIVE, 0, 20, "bomb_active after press");
    step;                                // bomb tile written by now
    model[spot_addr(row, col)] = BOMB;
  endtask

  task automatic report_test(int num, string name, int errs_before);
    if (err_cnt != errs_before) begin
      fail_cnt++;
      $display("test %0d %s: failed, %0d errors", num, name, err_cnt - errs_before);
    end else begin
      $display("test %0d %s: ok", num, name);
    end
  endtask

  // ---------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------
  initial begin
    int row_a, col_a, row_b, col_b, errs, boom_exp, done_exp;
    void'($urandom(32'hfbb1d122));
    rst = 1'b1;
    place_bomb = 1'b0;
    player_x = '0;
    player_y = '0;
    rd_addr = '0;
    boom_exp = 0;
    done_exp = 0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    load_model;

    errs = err_cnt;                      // 1: layout and idle outputs
    check_value("bomb_active", bomb_active, 0);
    check_value("countdown", countdown, `BOMB_TIME);
    check_value("explosion", explosion, 0);
    check_value("blast_done", blast_done, 0);
    compare_map;
    report_test(1, "reset layout", errs);

    errs = err_cnt;                      // 2: placement, extra presses ignored
    pick_spot(row_a, col_a);
    place_at(row_a, col_a);
    check_tile(spot_addr(row_a, col_a));
    do pick_spot(row_b, col_b); while (row_b == row_a && col_b == col_a);
    move_player(row_b, col_b);
    press_button;
    repeat (4) step;
    check_value("bomb_active", bomb_active, 1);
    check_tile(spot_addr(row_b, col_b));
    check_tile(spot_addr(row_a, col_a));
    report_test(2, "bomb placement", errs);

    errs = err_cnt;                      // 3: fuse, checked by the properties
    boom_exp++;
    wait_for(EV_BOOM, boom_exp, FUSE_CYCLES + 100, "explosion");
    report_test(3, "countdown", errs);

    errs = err_cnt;                      // 4: blast result
    done_exp++;
    wait_for(EV_DONE, done_exp, 200, "blast_done");
    apply_blast(spot_addr(row_a, col_a));
    compare_map;
    check_value("explosion count", explode_cnt, boom_exp);
    report_test(4, "blast map", errs);

    errs = err_cnt;                      // 5: new bomb while the blast runs
    pick_spot(row_a, col_a);
    place_at(row_a, col_a);
    boom_exp++;
    wait_for(EV_BOOM, boom_exp, FUSE_CYCLES + 100, "explosion");
    do pick_spot(row_b, col_b); while (row_b == row_a || col_b == col_a);
    place_at(row_b, col_b);
    done_exp++;
    wait_for(EV_DONE, done_exp, 200, "blast_done");
    apply_blast(spot_addr(row_a, col_a));
    compare_map;
    boom_exp++;
    wait_for(EV_BOOM, boom_exp, FUSE_CYCLES + 100, "second explosion");
    done_exp++;
    wait_for(EV_DONE, done_exp, 200, "second blast_done");
    apply_blast(spot_addr(row_b, col_b));
    compare_map;
    report_test(5, "press during blast", errs);

    errs = err_cnt;                      // 6: random placements back to back
    repeat (3) begin
      pick_spot(row_a, col_a);
      place_at(row_a, col_a);
      boom_exp++;
      wait_for(EV_BOOM, boom_exp, FUSE_CYCLES + 100, "explosion");
      done_exp++;
      wait_for(EV_DONE, done_exp, 200, "blast_done");
      apply_blast(spot_addr(row_a, col_a));
      compare_map;
    end
    report_test(6, "random bombs", errs);

    $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bomber_arena.f
+incdir+common
common/bomber_pkg.sv
bomb/bomb_logic.sv
bomb/blast_spread.sv
verilog/map_write_arbiter.sv
verilog/tile_map.sv
verilog/bomber_arena.sv
tb/tb_bomber_arena.sv
